//--- logic/bridge_defines.svh
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// bus and line geometry
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32
`define BRIDGE_LINE_W 512
`define BRIDGE_BEATS 16 // words per cache line

// axi field widths
`define BRIDGE_LEN_W 4
`define BRIDGE_ID_W 4

// read ids, bit 0 steers the return
`define BRIDGE_ID_INSTR 4'd0
`define BRIDGE_ID_DATA 4'd1

// burst types
`define BRIDGE_BURST_FIXED 2'b00
`define BRIDGE_BURST_INCR 2'b01

`endif

//--- logic/bridge_pkg.sv
`include "bridge_defines.svh"

package bridge_pkg;

	// line or word read from one cache
	typedef struct packed {
		logic req;
		logic [2:0] size;
		logic [`BRIDGE_ADDR_W-1:0] addr;
	} cache_rd_req_t;

	typedef struct packed {
		logic valid;
		logic last;
		logic [`BRIDGE_DATA_W-1:0] data;
	} cache_ret_t;

	// dcache write, line or single uncached word
	typedef struct packed {
		logic req;
		logic uncached;
		logic [2:0] size;
		logic [3:0] wstrb;
		logic [`BRIDGE_ADDR_W-1:0] addr;
		logic [`BRIDGE_DATA_W-1:0] word; // uncached data only
		logic [`BRIDGE_LINE_W-1:0] line;
	} cache_wr_req_t;

	typedef struct packed {
		logic [`BRIDGE_ID_W-1:0] id;
		logic [`BRIDGE_ADDR_W-1:0] addr;
		logic [`BRIDGE_LEN_W-1:0] len;
		logic [2:0] size;
		logic [1:0] burst;
	} axi_ar_t;

	typedef struct packed {
		logic [`BRIDGE_ADDR_W-1:0] addr;
		logic [`BRIDGE_LEN_W-1:0] len;
		logic [2:0] size;
		logic [1:0] burst;
	} axi_aw_t;

	typedef struct packed {
		logic [`BRIDGE_DATA_W-1:0] data;
		logic [3:0] strb;
		logic last;
	} axi_w_t;

	typedef enum logic [1:0] {rd_idle, rd_addr, rd_data, rd_done} rd_state_t;

	typedef enum logic [2:0] {wr_idle, wr_addr, wr_data, wr_resp, wr_done} wr_state_t;

endpackage

//--- logic/bridge_fsm.sv
`timescale 1ns/1ns

module bridge_fsm
	import bridge_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic icache_req,
	input logic dcache_req,
	input logic dwr_req,
	input logic arready,
	input logic awready,
	input logic wready,
	input logic wlast_beat,
	input logic rvalid,
	input logic rlast,
	input logic bvalid,
	output logic icache_rdy,
	output logic dcache_rdy,
	output logic wr_rdy,
	output logic rd_accept,
	output logic rd_pick_instr,
	output logic rd_in_data,
	output logic arvalid,
	output logic awvalid,
	output logic wvalid,
	output logic wr_accept,
	output logic beat_advance
);

	rd_state_t rd_state;
	rd_state_t rd_next;
	wr_state_t wr_state;
	wr_state_t wr_next;
	logic rd_free;
	logic wr_free;

	// read side handles one burst at a time
	assign rd_free = (rd_state == rd_idle) || (rd_state == rd_done);
	assign icache_rdy = rd_free;
	assign dcache_rdy = rd_free && !icache_req; // icache has priority
	assign rd_pick_instr = icache_req;
	assign rd_accept = rd_free && (icache_req || dcache_req);
	assign arvalid = (rd_state == rd_addr);
	assign rd_in_data = (rd_state == rd_data);

	always_ff @(posedge clk)
	begin
		if (!rst)
			rd_state <= rd_idle;
		else
			rd_state <= rd_next;
	end

	always_comb
	begin
		rd_next = rd_state;
		case (rd_state)
			rd_idle, rd_done:
				if (rd_accept)
					rd_next = rd_addr;
				else
					rd_next = rd_idle;
			rd_addr:
				if (arready)
					rd_next = rd_data;
			rd_data:
				if (rvalid && rlast) // rready tied high on the slave side
					rd_next = rd_done;
			default:
				rd_next = rd_idle;
		endcase
	end

	// write side
	assign wr_free = (wr_state == wr_idle) || (wr_state == wr_done);
	assign wr_rdy = wr_free;
	assign wr_accept = wr_free && dwr_req;
	assign awvalid = (wr_state == wr_addr);
	assign wvalid = (wr_state == wr_data);
	assign beat_advance = wvalid && wready;

	always_ff @(posedge clk)
	begin
		if (!rst)
			wr_state <= wr_idle;
		else
			wr_state <= wr_next;
	end

	always_comb
	begin
		wr_next = wr_state;
		case (wr_state)
			wr_idle, wr_done:
				if (wr_accept)
					wr_next = wr_addr;
				else
					wr_next = wr_idle;
			wr_addr:
				if (awready)
					wr_next = wr_data;
			wr_data:
				if (beat_advance && wlast_beat)
					wr_next = wr_resp;
			wr_resp:
				if (bvalid)
					wr_next = wr_done;
			default:
				wr_next = wr_idle;
		endcase
	end

endmodule

//--- logic/read_request_mux.sv
`timescale 1ns/1ns
`include "bridge_defines.svh"

module read_request_mux
	import bridge_pkg::*;
(
	input logic clk,
	input logic rst,
	input cache_rd_req_t icache,
	input cache_rd_req_t dcache,
	input logic dcache_uncached,
	input logic rd_accept,
	input logic rd_pick_instr,
	input logic rd_in_data,
	input logic rvalid,
	input logic rlast,
	input logic [`BRIDGE_ID_W-1:0] rid,
	input logic [`BRIDGE_DATA_W-1:0] rdata,
	output axi_ar_t ar,
	output cache_ret_t icache_ret,
	output cache_ret_t dcache_ret
);

	logic beat; // valid read beat in the data phase
	logic to_data; // rid bit 0 picks the cache

	// AR fields latched at acceptance and held while arvalid waits
	always_ff @(posedge clk)
	begin
		if (rd_accept)
		begin
			if (rd_pick_instr)
				ar <= '{id: `BRIDGE_ID_INSTR, addr: icache.addr,
					len: `BRIDGE_LEN_W'(`BRIDGE_BEATS - 1), size: icache.size,
					burst: `BRIDGE_BURST_INCR};
			else if (dcache_uncached)
				ar <= '{id: `BRIDGE_ID_DATA, addr: dcache.addr, len: '0,
					size: dcache.size, burst: `BRIDGE_BURST_FIXED}; // single word
			else
				ar <= '{id: `BRIDGE_ID_DATA, addr: dcache.addr,
					len: `BRIDGE_LEN_W'(`BRIDGE_BEATS - 1), size: dcache.size,
					burst: `BRIDGE_BURST_INCR};
		end
	end

	// returns are steered combinationally without buffering
	assign beat = rd_in_data && rvalid;
	assign to_data = rid[0];

	always_comb
	begin
		icache_ret.valid = beat && !to_data;
		icache_ret.last = beat && !to_data && rlast;
		icache_ret.data = rdata;
		dcache_ret.valid = beat && to_data;
		dcache_ret.last = beat && to_data && rlast;
		dcache_ret.data = rdata;
	end

	// slave must answer with the id that went out on AR
	assert property (@(posedge clk) disable iff (!rst) beat |-> rid == ar.id);

endmodule

//--- logic/write_line_buffer.sv
`timescale 1ns/1ns
`include "bridge_defines.svh"

module write_line_buffer
	import bridge_pkg::*;
(
	input logic clk,
	input logic rst,
	input cache_wr_req_t wr,
	input logic wr_accept,
	input logic beat_advance,
	output axi_aw_t aw,
	output axi_w_t w
);

	logic [`BRIDGE_LINE_W-1:0] line_q;
	logic [`BRIDGE_DATA_W-1:0] word_q;
	logic [`BRIDGE_ADDR_W-1:0] addr_q;
	logic [2:0] size_q;
	logic [3:0] strb_q;
	logic uncached_q;
	logic [3:0] beat_cnt;

	// capture on acceptance and shift one word per beat
	always_ff @(posedge clk)
	begin
		if (wr_accept)
		begin
			line_q <= wr.line;
			word_q <= wr.word;
			addr_q <= wr.addr;
			size_q <= wr.size;
			strb_q <= wr.wstrb;
			uncached_q <= wr.uncached;
		end
		else if (beat_advance)
			line_q <= {{`BRIDGE_DATA_W{1'b0}}, line_q[`BRIDGE_LINE_W-1:`BRIDGE_DATA_W]};
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			beat_cnt <= '0;
		else if (wr_accept)
			beat_cnt <= '0;
		else if (beat_advance)
			beat_cnt <= beat_cnt + 4'd1;
	end

	always_comb
	begin
		aw.addr = addr_q;
		aw.size = size_q;
		aw.len = uncached_q ? '0 : `BRIDGE_LEN_W'(`BRIDGE_BEATS - 1);
		aw.burst = uncached_q ? `BRIDGE_BURST_FIXED : `BRIDGE_BURST_INCR;
		w.data = uncached_q ? word_q : line_q[`BRIDGE_DATA_W-1:0]; // lowest word goes first
		w.strb = strb_q;
		w.last = uncached_q || (beat_cnt == 4'(`BRIDGE_BEATS - 1));
	end

	// no beat follows the final one, so the count cannot run past 15
	assert property (@(posedge clk) disable iff (!rst)
		beat_advance && w.last |=> !beat_advance);

endmodule

//--- logic/axi_cache_bridge.sv
`timescale 1ns/1ns
`include "bridge_defines.svh"

module axi_cache_bridge
	import bridge_pkg::*;
(
	input logic clk,
	input logic rst,
	// cache side
	input cache_rd_req_t icache_rd,
	input cache_rd_req_t dcache_rd,
	input logic dcache_uncached,
	output logic icache_rd_rdy,
	output logic dcache_rd_rdy,
	output cache_ret_t icache_ret,
	output cache_ret_t dcache_ret,
	input cache_wr_req_t dcache_wr,
	output logic dcache_wr_rdy,
	// axi read
	output axi_ar_t ar,
	output logic arvalid,
	input logic arready,
	input logic [`BRIDGE_ID_W-1:0] rid,
	input logic [`BRIDGE_DATA_W-1:0] rdata,
	input logic rlast,
	input logic rvalid,
	// axi write
	output axi_aw_t aw,
	output logic awvalid,
	input logic awready,
	output axi_w_t w,
	output logic wvalid,
	input logic wready,
	input logic bvalid
);

	logic rd_accept;
	logic rd_pick_instr;
	logic rd_in_data;
	logic wr_accept;
	logic beat_advance;

	bridge_fsm u_fsm (
		.clk(clk),
		.rst(rst),
		.icache_req(icache_rd.req),
		.dcache_req(dcache_rd.req),
		.dwr_req(dcache_wr.req),
		.arready(arready),
		.awready(awready),
		.wready(wready),
		.wlast_beat(w.last),
		.rvalid(rvalid),
		.rlast(rlast),
		.bvalid(bvalid),
		.icache_rdy(icache_rd_rdy),
		.dcache_rdy(dcache_rd_rdy),
		.wr_rdy(dcache_wr_rdy),
		.rd_accept(rd_accept),
		.rd_pick_instr(rd_pick_instr),
		.rd_in_data(rd_in_data),
		.arvalid(arvalid),
		.awvalid(awvalid),
		.wvalid(wvalid),
		.wr_accept(wr_accept),
		.beat_advance(beat_advance)
	);

	read_request_mux u_rd_mux (
		.clk(clk),
		.rst(rst),
		.icache(icache_rd),
		.dcache(dcache_rd),
		.dcache_uncached(dcache_uncached),
		.rd_accept(rd_accept),
		.rd_pick_instr(rd_pick_instr),
		.rd_in_data(rd_in_data),
		.rvalid(rvalid),
		.rlast(rlast),
		.rid(rid),
		.rdata(rdata),
		.ar(ar),
		.icache_ret(icache_ret),
		.dcache_ret(dcache_ret)
	);

	write_line_buffer u_wr_buf (
		.clk(clk),
		.rst(rst),
		.wr(dcache_wr),
		.wr_accept(wr_accept),
		.beat_advance(beat_advance),
		.aw(aw),
		.w(w)
	);

endmodule

//--- tests/axi_slave_model.sv
`timescale 1ns/1ns
`include "bridge_defines.svh"

module axi_slave_model
	import bridge_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic stall,
	input axi_ar_t ar,
	input logic arvalid,
	output logic arready,
	output logic [`BRIDGE_ID_W-1:0] rid,
	output logic [`BRIDGE_DATA_W-1:0] rdata,
	output logic rlast,
	output logic rvalid,
	input axi_aw_t aw,
	input logic awvalid,
	output logic awready,
	input axi_w_t w,
	input logic wvalid,
	output logic wready,
	output logic bvalid,
	output axi_aw_t aw_log,
	output logic [4:0] beats_logged
);

	int seed = 84042;
	logic [7:0] dice;
	logic go_ar;
	logic go_r;
	logic go_aw;
	logic go_w;
	axi_ar_t rd_cmd;
	logic [4:0] rd_beat;
	logic rd_busy;
	logic wr_busy;

	// word address plus a tag, so every beat is known from its address
	function automatic logic [31:0] beat_data(input logic [31:0] addr);
		return (addr >> 2) + 32'h5a00_0000;
	endfunction

	always @(posedge clk)
		dice <= 8'($random(seed));

	// each channel stalls one time in four when enabled
	assign go_ar = !stall || dice[1:0] != 2'b00;
	assign go_r = !stall || dice[3:2] != 2'b00;
	assign go_aw = !stall || dice[5:4] != 2'b00;
	assign go_w = !stall || dice[7:6] != 2'b00;

	always @(posedge clk)
	begin
		if (!rst)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
			rd_busy <= 1'b0;
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			wr_busy <= 1'b0;
			beats_logged <= '0;
		end
		else
		begin
			if (rvalid && rlast)
				rd_busy <= 1'b0;
			if (arvalid && arready)
			begin
				rd_cmd <= ar;
				rd_beat <= '0;
				rd_busy <= 1'b1;
				arready <= 1'b0;
			end
			else
				arready <= !rd_busy && go_ar;
			rvalid <= 1'b0; // every beat is taken, rready is high
			if (rd_busy && rd_beat <= 5'(rd_cmd.len) && go_r)
			begin
				rvalid <= 1'b1;
				rid <= rd_cmd.id;
				rdata <= beat_data(rd_cmd.burst == `BRIDGE_BURST_INCR ?
					rd_cmd.addr + 32'(rd_beat) * 32'd4 : rd_cmd.addr);
				rlast <= rd_beat == 5'(rd_cmd.len);
				rd_beat <= rd_beat + 5'd1;
			end
			if (awvalid && awready)
			begin
				aw_log <= aw;
				beats_logged <= '0;
				wr_busy <= 1'b1;
				awready <= 1'b0;
			end
			else
				awready <= !wr_busy && go_aw;
			bvalid <= 1'b0;
			if (wvalid && wready)
			begin
				beats_logged <= beats_logged + 5'd1;
				if (w.last)
				begin
					wr_busy <= 1'b0;
					bvalid <= 1'b1; // response right after the last beat
				end
			end
			wready <= wr_busy && go_w && !(wvalid && wready && w.last);
		end
	end

endmodule

//--- tests/tb_axi_cache_bridge.sv
`timescale 1ns/1ns
`include "bridge_defines.svh"

module tb_axi_cache_bridge
	import bridge_pkg::*;
();

	localparam int TIMEOUT = 500;
	localparam int EV_RD_ACCEPT = 0;
	localparam int EV_RD_LAST = 1;
	localparam int EV_WR_ACCEPT = 2;
	localparam int EV_WR_DONE = 3;

	logic clk = 1'b0;
	logic rst;
	logic stall;
	cache_rd_req_t icache_rd;
	cache_rd_req_t dcache_rd;
	logic dcache_uncached;
	logic icache_rd_rdy;
	logic dcache_rd_rdy;
	cache_ret_t icache_ret;
	cache_ret_t dcache_ret;
	cache_wr_req_t dcache_wr;
	logic dcache_wr_rdy;
	axi_ar_t ar;
	logic arvalid;
	logic arready;
	logic [`BRIDGE_ID_W-1:0] rid;
	logic [`BRIDGE_DATA_W-1:0] rdata;
	logic rlast;
	logic rvalid;
	axi_aw_t aw;
	logic awvalid;
	logic awready;
	axi_w_t w;
	logic wvalid;
	logic wready;
	logic bvalid;
	axi_aw_t aw_log;
	logic [4:0] beats_logged;

	// what the bridge should be doing, captured at each acceptance
	cache_rd_req_t rd_cap;
	logic rd_instr;
	logic rd_unc;
	logic [4:0] rd_beat;
	cache_wr_req_t wr_cap;
	logic [4:0] wr_beat;
	logic [4:0] exp_beats;
	axi_ar_t exp_ar;
	axi_aw_t exp_aw;
	logic [34:0] ret_got;
	logic [34:0] ret_exp;
	logic [36:0] w_got;
	logic [36:0] w_exp;
	int rd_accepts;
	int rd_lasts;
	int wr_accepts;
	int wr_dones;
	int returns;
	int beats;
	int errors = 0;
	int timeouts = 0;
	int seed = 84042;

	axi_cache_bridge dut (.*);
	axi_slave_model slave (.*);

	always #10 clk = ~clk;

	function automatic logic [31:0] word_at(input logic [31:0] addr);
		return (addr >> 2) + 32'h5a00_0000; // slave tag on the word address
	endfunction

	always_comb
	begin
		exp_ar.id = rd_instr ? `BRIDGE_ID_INSTR : `BRIDGE_ID_DATA;
		exp_ar.addr = rd_cap.addr;
		exp_ar.len = rd_unc ? 4'd0 : 4'd15;
		exp_ar.size = rd_cap.size;
		exp_ar.burst = rd_unc ? `BRIDGE_BURST_FIXED : `BRIDGE_BURST_INCR;
		exp_aw.addr = wr_cap.addr;
		exp_aw.len = wr_cap.uncached ? 4'd0 : 4'd15;
		exp_aw.size = wr_cap.size;
		exp_aw.burst = wr_cap.uncached ? `BRIDGE_BURST_FIXED : `BRIDGE_BURST_INCR;
		exp_beats = wr_cap.uncached ? 5'd1 : 5'd16;
		// valid pair, data, last
		ret_exp = {rd_instr, !rd_instr,
			word_at(rd_unc ? rd_cap.addr : rd_cap.addr + 32'(rd_beat) * 32'd4),
			rd_beat == (rd_unc ? 5'd0 : 5'd15)};
		ret_got = {icache_ret.valid, dcache_ret.valid,
			icache_ret.valid ? icache_ret.data : dcache_ret.data,
			icache_ret.last || dcache_ret.last};
		w_exp = {wr_cap.uncached ? wr_cap.word : wr_cap.line[32 * wr_beat +: 32],
			wr_cap.wstrb, wr_beat == exp_beats - 5'd1};
		w_got = {w.data, w.strb, w.last};
	end

	always @(posedge clk)
	begin
		if (!rst)
		begin
			rd_accepts <= 0;
			rd_lasts <= 0;
			wr_accepts <= 0;
			wr_dones <= 0;
			returns <= 0;
			beats <= 0;
		end
		else
		begin
			if ((icache_rd.req && icache_rd_rdy) || (dcache_rd.req && dcache_rd_rdy))
			begin
				rd_instr <= icache_rd.req; // icache wins a tie
				rd_cap <= icache_rd.req ? icache_rd : dcache_rd;
				rd_unc <= !icache_rd.req && dcache_uncached;
				rd_beat <= '0;
				rd_accepts <= rd_accepts + 1;
			end
			if (icache_ret.valid || dcache_ret.valid)
			begin
				rd_beat <= rd_beat + 5'd1;
				returns <= returns + 1;
				if (icache_ret.last || dcache_ret.last)
					rd_lasts <= rd_lasts + 1;
			end
			if (dcache_wr.req && dcache_wr_rdy)
			begin
				wr_cap <= dcache_wr;
				wr_beat <= '0;
				wr_accepts <= wr_accepts + 1;
			end
			if (wvalid && wready)
			begin
				wr_beat <= wr_beat + 5'd1;
				beats <= beats + 1;
			end
			if (bvalid)
				wr_dones <= wr_dones + 1;
		end
	end

	assert property (@(posedge clk) disable iff (!rst) arvalid |-> ar == exp_ar)
	else
	begin
		errors = errors + 1;
		$display("Mismatch ar: got %h expected %h", $sampled(ar), $sampled(exp_ar));
	end

	assert property (@(posedge clk) disable iff (!rst) awvalid |-> aw == exp_aw)
	else
	begin
		errors = errors + 1;
		$display("Mismatch aw: got %h expected %h", $sampled(aw), $sampled(exp_aw));
	end

	assert property (@(posedge clk) disable iff (!rst)
		(icache_ret.valid || dcache_ret.valid) |-> ret_got == ret_exp)
	else
	begin
		errors = errors + 1;
		$display("Mismatch ret {ivalid, dvalid, data, last}: got %h expected %h",
			$sampled(ret_got), $sampled(ret_exp));
	end

	assert property (@(posedge clk) disable iff (!rst) (wvalid && wready) |-> w_got == w_exp)
	else
	begin
		errors = errors + 1;
		$display("Mismatch w {data, strb, last}: got %h expected %h",
			$sampled(w_got), $sampled(w_exp));
	end

	// slave log at the write response
	assert property (@(posedge clk) disable iff (!rst)
		bvalid |-> {aw_log, beats_logged} == {exp_aw, exp_beats})
	else
	begin
		errors = errors + 1;
		$display("Mismatch slave log {aw, beats}: got %h expected %h",
			$sampled({aw_log, beats_logged}), $sampled({exp_aw, exp_beats}));
	end

	assert property (@(posedge clk) disable iff (!rst)
		(icache_rd.req && dcache_rd.req && icache_rd_rdy) |-> !dcache_rd_rdy)
	else
	begin
		errors = errors + 1;
		$display("data cache was offered acceptance while the instruction cache requested");
	end

	assert property (@(posedge clk) disable iff (!rst) arvalid && !arready |=> arvalid)
	else
	begin
		errors = errors + 1;
		$display("arvalid dropped before its handshake");
	end

	assert property (@(posedge clk) disable iff (!rst) awvalid && !awready |=> awvalid)
	else
	begin
		errors = errors + 1;
		$display("awvalid dropped before its handshake");
	end

	function automatic int progress(input int which);
		case (which)
			EV_RD_ACCEPT: return rd_accepts;
			EV_RD_LAST: return rd_lasts;
			EV_WR_ACCEPT: return wr_accepts;
			default: return wr_dones;
		endcase
	endfunction

	// step falling edges until the chosen counter reaches target
	task automatic wait_for(input int which, input int target, input string what);
		int n;
		n = 0;
		while (progress(which) < target && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (progress(which) < target)
		begin
			timeouts++;
			$display("timeout while waiting for %s", what);
		end
	endtask

	task automatic read_line(input logic instr, input logic [31:0] addr, input logic uncached);
		int target;
		target = rd_lasts + 1;
		if (instr)
		begin
			icache_rd.req = 1'b1;
			icache_rd.addr = addr;
		end
		else
		begin
			dcache_rd.req = 1'b1;
			dcache_rd.addr = addr;
			dcache_uncached = uncached;
		end
		wait_for(EV_RD_ACCEPT, rd_accepts + 1, "read acceptance");
		icache_rd.req = 1'b0;
		dcache_rd.req = 1'b0;
		dcache_uncached = 1'b0;
		wait_for(EV_RD_LAST, target, "last read return");
	endtask

	// both caches raise req on the same edge
	task automatic read_both(input logic [31:0] iaddr, input logic [31:0] daddr);
		int first;
		int lasts;
		first = rd_accepts;
		lasts = rd_lasts;
		icache_rd.req = 1'b1;
		icache_rd.addr = iaddr;
		dcache_rd.req = 1'b1;
		dcache_rd.addr = daddr;
		wait_for(EV_RD_ACCEPT, first + 1, "instruction read acceptance");
		icache_rd.req = 1'b0;
		wait_for(EV_RD_ACCEPT, first + 2, "data read acceptance");
		dcache_rd.req = 1'b0;
		wait_for(EV_RD_LAST, lasts + 2, "both read bursts");
	endtask

	task automatic write_req(input logic uncached, input logic [31:0] addr);
		int k;
		dcache_wr.req = 1'b1;
		dcache_wr.uncached = uncached;
		dcache_wr.addr = addr;
		dcache_wr.size = 3'd2;
		dcache_wr.wstrb = uncached ? 4'h3 : 4'hf;
		dcache_wr.word = $random(seed);
		for (k = 0; k < `BRIDGE_BEATS; k++)
			dcache_wr.line[32 * k +: 32] = $random(seed);
		wait_for(EV_WR_ACCEPT, wr_accepts + 1, "write acceptance");
		dcache_wr.req = 1'b0;
		wait_for(EV_WR_DONE, wr_dones + 1, "write response");
	endtask

	initial
	begin
		rst = 1'b0;
		stall = 1'b0;
		icache_rd = '0;
		dcache_rd = '0;
		dcache_uncached = 1'b0;
		dcache_wr = '0;
		icache_rd.size = 3'd2;
		dcache_rd.size = 3'd2;
		repeat (8) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		read_line(1'b1, 32'h0000_1040, 1'b0);
		read_line(1'b0, 32'h0000_2008, 1'b1);
		read_both(32'h0000_3000, 32'h0000_4100);
		write_req(1'b0, 32'h0000_5000);
		write_req(1'b1, 32'h0000_6004);
		stall = 1'b1; // random ready stalls from here on
		read_line(1'b1, 32'h0000_7080, 1'b0);
		write_req(1'b0, 32'h0000_8000);
		read_both(32'h0000_9040, 32'h0000_a0c0);
		$display("read returns %0d, write beats %0d, errors %0d, timeouts %0d",
			returns, beats, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- axi_cache_bridge.f
+incdir+logic
logic/bridge_pkg.sv
logic/bridge_fsm.sv
logic/read_request_mux.sv
logic/write_line_buffer.sv
logic/axi_cache_bridge.sv
tests/axi_slave_model.sv
tests/tb_axi_cache_bridge.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_axi_cache_bridge -Mdir obj_dir \
	-f axi_cache_bridge.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_axi_cache_bridge)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^ALL CHECKS PASSED$"; then
	exit 0
fi
exit 1
